// File: hdl/keyboardPkg.sv
package keyboardPkg;

	// ----------------------------------------
	// PS/2 set 2 scan codes
	// ----------------------------------------
	localparam int scanWidth = 8;	// one scan byte

	// key up is sent as F0 then the make code
	localparam logic [scanWidth-1:0] breakPrefix = 8'hF0;

	// make codes for the drum keys
	localparam logic [scanWidth-1:0] codeKeyF = 8'h2B;	// left drum
	localparam logic [scanWidth-1:0] codeKeyG = 8'h34;	// bass
	localparam logic [scanWidth-1:0] codeKeyH = 8'h33;	// middle drum
	localparam logic [scanWidth-1:0] codeKeyJ = 8'h3B;	// cymbal

	// ----------------------------------------
	// held key flags
	// ----------------------------------------
	// f sits in the msb, j in the lsb
	typedef struct packed {
		logic f;	// left drum held
		logic g;	// bass held
		logic h;	// middle drum held
		logic j;	// cymbal held
	} drumKeys_t;

endpackage

// File: hdl/audioPkg.sv
package audioPkg;

	// ----------------------------------------
	// sample and audio word widths
	// ----------------------------------------
	localparam int sampleWidth = 8;		// signed rom sample
	localparam int audioWidth = 32;		// signed codec word
	localparam int gainShift = 20;		// sample * 2^20 into the audio word

	// ----------------------------------------
	// playback timing and rom layout
	// ----------------------------------------
	localparam int sampleDivide = 4;	// clocks per sample step
	localparam int drumLength = 8;		// samples per drum
	localparam int drumCount = 4;
	localparam int drumAddrWidth = 4;	// wide enough to hold drumLength, the done value
	localparam int romAddrWidth = 5;	// drumCount * drumLength words

	typedef logic signed [sampleWidth-1:0] sample_t;
	typedef logic signed [audioWidth-1:0] audio_t;

	// drum number is also the rom block index
	typedef enum logic [1:0] {
		leftDrum = 2'd0,
		bassDrum = 2'd1,
		middleDrum = 2'd2,
		cymbal = 2'd3
	} drumSel_t;

	typedef struct packed {
		drumSel_t drum;					// drum currently selected
		logic [romAddrWidth-1:0] romAddr;	// word to read next
		logic playing;					// held drum still has samples left
	} voice_t;

endpackage

// File: hdl/scanDecoder.sv
`timescale 1ns/1ps

// turns the ps/2 byte stream into held flags for the four drum keys
module scanDecoder
	import keyboardPkg::*;
(
	input logic CLOCK_50,
	input logic recievedNewData,	// async reset, active high
	input logic [scanWidth-1:0] scanByte,
	input logic scanStrobe,		// scanByte valid this cycle
	output drumKeys_t keys
);

	logic breakPending;	// last byte was F0
	logic keyLevel;		// value written into a matching key flag

	// a make code sets the flag, a code after F0 clears it
	assign keyLevel = ~breakPending;

	// ----------------------------------------
	// byte handling
	// ----------------------------------------
	always_ff @(posedge CLOCK_50 or posedge recievedNewData) begin
		if (recievedNewData) begin
			breakPending <= 1'b0;
			keys <= '0;	// nothing held
		end
		else if (scanStrobe) begin
			if (scanByte == breakPrefix) begin
				breakPending <= 1'b1;	// key state waits for the next byte
			end
			else begin
				breakPending <= 1'b0;	// any other byte consumes the prefix
				case (scanByte)
					codeKeyF: keys.f <= keyLevel;
					codeKeyG: keys.g <= keyLevel;
					codeKeyH: keys.h <= keyLevel;
					codeKeyJ: keys.j <= keyLevel;
					default: ;	// not a drum key, flags untouched
				endcase
			end
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	// the prefix alone must never move a key flag, only the byte after it
	prefixHoldsKeys: assert property (
		@(posedge CLOCK_50) disable iff (recievedNewData)
		(scanStrobe && scanByte == breakPrefix) |=> $stable(keys)
	) else $error("key state changed on a break prefix byte");

endmodule

// File: hdl/drumVoice.sv
`timescale 1ns/1ps

// picks the drum to play and steps through its samples at the sample rate
module drumVoice
	import keyboardPkg::*, audioPkg::*;
(
	input logic CLOCK_50,
	input logic recievedNewData,	// async reset, active high
	input drumKeys_t keys,
	output voice_t voice
);

	logic [$clog2(sampleDivide)-1:0] divCount;		// sample rate divider
	logic [drumAddrWidth-1:0] drumAddr [drumCount];	// one position per drum
	logic [drumAddrWidth-1:0] selAddr;				// position of the chosen drum
	drumSel_t sel;
	logic anyKey;
	logic lastCount;	// divider at its final count
	logic selDone;		// chosen drum ran out of samples

	// ----------------------------------------
	// fixed priority F, G, H, J
	// ----------------------------------------
	always_comb begin
		if (keys.f) sel = leftDrum;
		else if (keys.g) sel = bassDrum;
		else if (keys.h) sel = middleDrum;
		else sel = cymbal;	// also the idle value, gated by anyKey
	end

	assign anyKey = |keys;
	assign selAddr = drumAddr[sel];
	assign selDone = (selAddr == drumLength);
	assign lastCount = (divCount == $bits(divCount)'(sampleDivide - 1));

	// ----------------------------------------
	// divider and address counters
	// ----------------------------------------
	always_ff @(posedge CLOCK_50 or posedge recievedNewData) begin
		if (recievedNewData) begin
			divCount <= '0;
			for (int i = 0; i < drumCount; i++) begin
				drumAddr[i] <= '0;
			end
		end
		else if (!anyKey) begin
			// all keys up, every drum starts over on the next press
			divCount <= '0;
			for (int i = 0; i < drumCount; i++) begin
				drumAddr[i] <= '0;
			end
		end
		else begin
			divCount <= lastCount ? '0 : divCount + 1'b1;
			if (lastCount && !selDone) begin
				drumAddr[sel] <= selAddr + 1'b1;	// only the chosen drum moves
			end
		end
	end

	// ----------------------------------------
	// registered voice
	// ----------------------------------------
	always_ff @(posedge CLOCK_50 or posedge recievedNewData) begin
		if (recievedNewData) begin
			voice <= '0;
		end
		else begin
			voice.drum <= sel;
			// drum blocks sit back to back in the rom
			voice.romAddr <= romAddrWidth'(sel * drumLength + selAddr);
			voice.playing <= anyKey && !selDone;	// finished drum stays silent
		end
	end

	// no counter may run past the done value
	for (genvar d = 0; d < drumCount; d++) begin : addrCheck
		addrInRange: assert property (
			@(posedge CLOCK_50) disable iff (recievedNewData)
			drumAddr[d] <= drumLength
		) else $error("drum %0d address past end of sample", d);
	end

endmodule

// File: hdl/drumSampleRom.sv
`timescale 1ns/1ps

// all four drum samples in one block, drum 0 at the bottom
module drumSampleRom
	import audioPkg::*;
(
	input logic CLOCK_50,
	input logic [romAddrWidth-1:0] romAddr,
	output sample_t sample
);

	sample_t romData [drumCount*drumLength];

	// ----------------------------------------
	// contents
	// ----------------------------------------
	initial begin
		$readmemh("drums.hex", romData);	// eight words per drum
	end

	// one cycle read, maps to block ram
	always_ff @(posedge CLOCK_50) begin
		sample <= romData[romAddr];
	end

endmodule

// File: hdl/audioMixer.sv
`timescale 1ns/1ps

// scales the rom sample into the codec word, silent when nothing plays
module audioMixer
	import audioPkg::*;
(
	input logic CLOCK_50,
	input logic recievedNewData,	// async reset, active high
	input logic playing,
	input sample_t sample,
	output audio_t audioOut
);

	logic playingD;	// playing lined up with the rom output

	// ----------------------------------------
	// gate and scale
	// ----------------------------------------
	always_ff @(posedge CLOCK_50 or posedge recievedNewData) begin
		if (recievedNewData) begin
			playingD <= 1'b0;
			audioOut <= '0;
		end
		else begin
			playingD <= playing;	// rom adds one cycle
			if (playingD) begin
				audioOut <= audio_t'(sample) <<< gainShift;	// sign extend, then * 2^20
			end
			else begin
				audioOut <= '0;
			end
		end
	end

	// low bits never carry sample data
	gainAligned: assert property (
		@(posedge CLOCK_50) disable iff (recievedNewData)
		audioOut[gainShift-1:0] == '0
	) else $error("audio word not a multiple of the gain");

endmodule

// File: hdl/drumMachineTop.sv
`timescale 1ns/1ps

// keyboard drum machine, scan bytes in, audio word out
module drumMachineTop
	import keyboardPkg::*, audioPkg::*;
(
	input logic CLOCK_50,
	input logic recievedNewData,	// async reset, active high
	input logic [scanWidth-1:0] scanByte,
	input logic scanStrobe,
	output audio_t audioOut,
	output logic drumBusy
);

	drumKeys_t keys;	// held drum keys
	voice_t voice;		// chosen drum and rom position
	sample_t sample;	// rom read data

	// ----------------------------------------
	// input side
	// ----------------------------------------
	scanDecoder scanDecoder_i (
		.CLOCK_50(CLOCK_50),
		.recievedNewData(recievedNewData),
		.scanByte(scanByte),
		.scanStrobe(scanStrobe),
		.keys(keys)
	);

	drumVoice drumVoice_i (
		.CLOCK_50(CLOCK_50),
		.recievedNewData(recievedNewData),
		.keys(keys),
		.voice(voice)
	);

	// ----------------------------------------
	// sample path
	// ----------------------------------------
	drumSampleRom drumSampleRom_i (
		.CLOCK_50(CLOCK_50),
		.romAddr(voice.romAddr),
		.sample(sample)
	);

	audioMixer audioMixer_i (
		.CLOCK_50(CLOCK_50),
		.recievedNewData(recievedNewData),
		.playing(voice.playing),
		.sample(sample),
		.audioOut(audioOut)
	);

	assign drumBusy = voice.playing;	// already registered in drumVoice

endmodule

// File: test/drumMachineTb.sv
`timescale 1ns/1ps

module drumMachineTb
	import keyboardPkg::*, audioPkg::*;
();

	localparam int pressCount = 9;	// key presses over all tests
	localparam int testLength = drumLength * sampleDivide + 20;
	localparam int timeoutLimit = pressCount * testLength + 200;

	logic CLOCK_50;
	logic recievedNewData;
	logic [scanWidth-1:0] scanByte;
	logic scanStrobe;
	audio_t audioOut;
	logic drumBusy;

	sample_t romWords [drumCount*drumLength];	// same image as the rom
	drumKeys_t mKeys;		// model key flags
	logic mBreak;			// model break prefix seen
	int mDiv;
	int mAddr [drumCount];
	audio_t audioPipe [3];	// model output, three edges deep
	logic expBusy;
	string testName;
	int cycleCount;
	int seed;

	drumMachineTop dut_i (
		.CLOCK_50(CLOCK_50),
		.recievedNewData(recievedNewData),
		.scanByte(scanByte),
		.scanStrobe(scanStrobe),
		.audioOut(audioOut),
		.drumBusy(drumBusy)
	);

	always #4 CLOCK_50 = ~CLOCK_50;	// 8 ns period

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic int heldDrum(drumKeys_t k);
		if (k.f) return 0;	// left drum wins
		if (k.g) return 1;
		if (k.h) return 2;
		return 3;
	endfunction

	function automatic logic expectedBusy(drumKeys_t k);
		return (k != '0) && (mAddr[heldDrum(k)] < drumLength);
	endfunction

	// audio word for the current model state, seen on audioOut three edges on
	function automatic audio_t expectedAudio(drumKeys_t k);
		int d;
		d = heldDrum(k);
		if (!expectedBusy(k)) return '0;
		return $signed(romWords[d*drumLength + mAddr[d]]) * (2 ** gainShift);
	endfunction

	always @(posedge CLOCK_50) begin : modelStep
		int d;
		if (recievedNewData) begin
			mKeys = '0;
			mBreak = 1'b0;
			mDiv = 0;
			foreach (mAddr[i]) mAddr[i] = 0;
			foreach (audioPipe[i]) audioPipe[i] = '0;
			expBusy = 1'b0;
		end
		else begin
			audioPipe[2] = audioPipe[1];
			audioPipe[1] = audioPipe[0];
			audioPipe[0] = expectedAudio(mKeys);
			expBusy = expectedBusy(mKeys);
			d = heldDrum(mKeys);
			// sample clock runs only while a key is down
			if (mKeys == '0) begin
				mDiv = 0;
				foreach (mAddr[i]) mAddr[i] = 0;
			end
			else if (mDiv == sampleDivide - 1) begin
				mDiv = 0;
				if (mAddr[d] < drumLength) mAddr[d]++;
			end
			else mDiv++;
			// key flags follow the byte stream
			if (scanStrobe && scanByte == breakPrefix) mBreak = 1'b1;
			else if (scanStrobe) begin
				if (scanByte == codeKeyF) mKeys.f = !mBreak;
				if (scanByte == codeKeyG) mKeys.g = !mBreak;
				if (scanByte == codeKeyH) mKeys.h = !mBreak;
				if (scanByte == codeKeyJ) mKeys.j = !mBreak;
				mBreak = 1'b0;	// prefix used up by any byte
			end
		end
	end

	// ----------------------------------------
	// checks and timeout
	// ----------------------------------------
	task automatic checkValue(input string name, input logic [audioWidth-1:0] expected,
			input logic [audioWidth-1:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// outputs settle after the rising edge, compare on the falling one
	always @(negedge CLOCK_50) begin
		checkValue({testName, " audioOut"}, audioPipe[2], audioOut);
		checkValue({testName, " drumBusy"}, expBusy, drumBusy);
	end

	always @(posedge CLOCK_50) begin
		cycleCount++;
		if (cycleCount > timeoutLimit) begin
			$display("timeout: run still going after %0d cycles", timeoutLimit);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic sendByte(input logic [scanWidth-1:0] b);
		@(posedge CLOCK_50);
		scanByte <= b;
		scanStrobe <= 1'b1;	// one cycle strobe
		@(posedge CLOCK_50);
		scanStrobe <= 1'b0;
	endtask

	task automatic releaseKey(input logic [scanWidth-1:0] code);
		sendByte(breakPrefix);
		sendByte(code);
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(posedge CLOCK_50);
	endtask

	// press, wait for the voice to finish, count how long it was busy
	task automatic playAlone(input logic [scanWidth-1:0] code, input string name);
		int busyCycles;
		testName = name;
		sendByte(code);
		@(negedge CLOCK_50);
		while (!drumBusy) @(negedge CLOCK_50);
		busyCycles = 0;
		while (drumBusy) begin
			busyCycles++;
			@(negedge CLOCK_50);
		end
		checkValue({name, " length"}, drumLength * sampleDivide, busyCycles);
		waitCycles(6);	// still held, must stay quiet
		releaseKey(code);
		waitCycles(6);
	endtask

	initial begin
		logic [scanWidth-1:0] b;
		CLOCK_50 = 1'b0;
		recievedNewData = 1'b1;
		scanByte = '0;
		scanStrobe = 1'b0;
		cycleCount = 0;
		seed = $urandom(76);
		testName = "reset";
		$readmemh("drums.hex", romWords);
		waitCycles(10);
		recievedNewData <= 1'b0;
		waitCycles(5);

		playAlone(codeKeyF, "single F");
		playAlone(codeKeyG, "single G");
		playAlone(codeKeyH, "single H");
		playAlone(codeKeyJ, "single J");

		testName = "priority";
		sendByte(codeKeyF);
		sendByte(codeKeyG);
		waitCycles(12);
		releaseKey(codeKeyF);	// bass takes over from sample 0
		waitCycles(40);
		releaseKey(codeKeyG);
		waitCycles(6);

		testName = "early release";
		sendByte(codeKeyH);
		waitCycles(10);
		releaseKey(codeKeyH);
		waitCycles(6);
		sendByte(codeKeyH);	// restarts at sample 0
		waitCycles(40);
		releaseKey(codeKeyH);
		waitCycles(6);

		// random non drum bytes, half of them after a prefix
		testName = "ignored traffic";
		repeat (20) begin
			b = $urandom % 256;
			while (b == breakPrefix || b == codeKeyF || b == codeKeyG ||
					b == codeKeyH || b == codeKeyJ) b = $urandom % 256;
			if ($urandom % 2) sendByte(breakPrefix);
			sendByte(b);
		end
		sendByte(codeKeyJ);
		waitCycles(4);
		sendByte(breakPrefix);
		sendByte(8'h1C);	// A key, not a drum
		waitCycles(2);	// byte has reached the voice by now
		@(negedge CLOCK_50);
		checkValue("ignored traffic held", 1, drumBusy);
		waitCycles(40);
		releaseKey(codeKeyJ);
		waitCycles(6);

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: drums.hex
// one signed 8-bit sample per line, two hex digits
// drums in order left, bass, middle, cymbal, eight samples each
// left drum
7F
A2
58
C4
30
E2
12
F6
// bass
5C
7F
44
E0
B3
D6
14
04
// middle drum
70
90
48
BC
26
DA
0E
FA
// cymbal
3A
C8
66
9E
52
B0
2C
E8

// File: flist.f
hdl/keyboardPkg.sv
hdl/audioPkg.sv
hdl/scanDecoder.sv
hdl/drumVoice.sv
hdl/drumSampleRom.sv
hdl/audioMixer.sv
hdl/drumMachineTop.sv
test/drumMachineTb.sv
